// File: logic/msx_bus_pkg.sv
// bus-side widths and types
// segment register I/O port numbers
`default_nettype none

package msx_bus_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int bus_addr_bits = 16;
	localparam int bus_data_bits = 8;
	localparam int segment_bits = 8;
	// page is the top of the address, offset the rest
	localparam int page_bits = 2;
	localparam int offset_bits = bus_addr_bits - page_bits;

	typedef logic [bus_addr_bits-1:0] bus_addr_t;
	typedef logic [bus_data_bits-1:0] bus_data_t;
	typedef logic [segment_bits-1:0] segment_t;
	typedef logic [page_bits-1:0] page_t;
	typedef logic [offset_bits-1:0] offset_t;

	// ------------------------------
	// mapper I/O ports
	// ------------------------------
	// page 0 register, pages 1..3 follow at FD, FE, FF
	localparam logic [7:0] mapper_port_base = 8'hFC;
	localparam int mapper_pages = 2 ** page_bits;

endpackage

`default_nettype wire

// File: logic/ram_pkg.sv
// memory-side widths and the RAM request struct
// request buffer depth, read latency, refresh timing
`default_nettype none

package ram_pkg;

	// ------------------------------
	// addresses
	// ------------------------------
	// segment above a 14-bit offset, 22 bits
	localparam int ram_addr_bits = msx_bus_pkg::segment_bits + msx_bus_pkg::offset_bits;
	typedef logic [ram_addr_bits-1:0] ram_addr_t;

	// implemented array, 256 KiB
	// only 16 segments exist, upper segment bits alias
	localparam int ram_size_bits = 18;
	typedef logic [ram_size_bits-1:0] ram_index_t;

	// one memory access from mapper to controller
	typedef struct packed {
		logic wr;
		ram_addr_t addr;
		msx_bus_pkg::bus_data_t data;
	} ram_req_t;

	// ------------------------------
	// request buffer
	// ------------------------------
	localparam int fifo_depth = 4;
	localparam int fifo_ptr_bits = $clog2(fifo_depth);
	typedef logic [fifo_ptr_bits-1:0] fifo_ptr_t;
	// one extra bit so a full buffer is countable
	typedef logic [fifo_ptr_bits:0] fifo_count_t;

	// ------------------------------
	// controller timing
	// ------------------------------
	// pop of a read to rdata_en
	localparam int read_latency = 2;
	// refresh_len stalled cycles in every refresh_period
	localparam int refresh_period = 64;
	localparam int refresh_len = 4;
	localparam int refresh_cnt_bits = $clog2(refresh_period);
	typedef logic [refresh_cnt_bits-1:0] refresh_cnt_t;

endpackage

`default_nettype wire

// File: logic/ram_req_fifo.sv
// in-order request queue between mapper and RAM controller
// circular buffer with read/write pointers and a count
`timescale 1ns/1ps
`default_nettype none

module ram_req_fifo (
	input wire clk,
	input wire n_reset,
	// write side, from the mapper
	input wire ram_pkg::ram_req_t push_req,
	input wire push,
	output logic full,
	// read side, to the controller
	output ram_pkg::ram_req_t head_req,
	output logic not_empty,
	input wire pop
);

	ram_pkg::ram_req_t entries [ram_pkg::fifo_depth];
	ram_pkg::fifo_ptr_t wr_ptr_q;
	ram_pkg::fifo_ptr_t rd_ptr_q;
	ram_pkg::fifo_count_t count_q;
	logic do_push;
	logic do_pop;

	// pointer step with wrap at the last entry
	function automatic ram_pkg::fifo_ptr_t next_ptr(input ram_pkg::fifo_ptr_t p);
		if (p == ram_pkg::fifo_ptr_t'(ram_pkg::fifo_depth - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	// ------------------------------
	// status
	// ------------------------------
	assign full = (count_q == ram_pkg::fifo_count_t'(ram_pkg::fifo_depth));
	assign not_empty = (count_q != '0);

	assign do_pop = pop && not_empty;
	// a pop in the same cycle frees the slot of a full buffer
	assign do_push = push && (!full || do_pop);

	// head straight from storage, poppable one edge after its push
	assign head_req = entries[rd_ptr_q];

	// ------------------------------
	// storage
	// ------------------------------
	always_ff @(posedge clk) begin
		if (do_push) begin
			entries[wr_ptr_q] <= push_req;
		end
	end

	// ------------------------------
	// pointers and count
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (do_pop) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			// count moves only when one side acts alone
			case ({do_push, do_pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/ram_array_ctrl.sv
// on-chip byte RAM behind the request buffer
// periodic refresh stalls, fixed-latency read return
`timescale 1ns/1ps
`default_nettype none

module ram_array_ctrl (
	input wire clk,
	input wire n_reset,
	// request buffer head
	input wire ram_pkg::ram_req_t head_req,
	input wire not_empty,
	output logic pop,
	// read return, in request order
	output msx_bus_pkg::bus_data_t rdata,
	output logic rdata_en
);

	typedef enum logic {
		st_idle,
		st_refresh
	} state_t;

	state_t state_q;
	ram_pkg::refresh_cnt_t refresh_cnt_q;
	msx_bus_pkg::bus_data_t mem [2 ** ram_pkg::ram_size_bits];
	ram_pkg::ram_index_t index;
	msx_bus_pkg::bus_data_t data_pipe [ram_pkg::read_latency];
	logic [ram_pkg::read_latency-1:0] valid_pipe;
	logic read_pop;

	// ------------------------------
	// refresh timing
	// ------------------------------
	// free-running, one lap per refresh period
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			refresh_cnt_q <= '0;
		end else if (refresh_cnt_q ==
			ram_pkg::refresh_cnt_t'(ram_pkg::refresh_period - 1)) begin
			refresh_cnt_q <= '0;
		end else begin
			refresh_cnt_q <= refresh_cnt_q + 1'b1;
		end
	end

	// refresh takes the last refresh_len cycles of each lap
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state_q <= st_idle;
		end else begin
			case (state_q)
				st_idle: begin
					if (refresh_cnt_q == ram_pkg::refresh_cnt_t'(
						ram_pkg::refresh_period - ram_pkg::refresh_len - 1)) begin
						state_q <= st_refresh;
					end
				end
				st_refresh: begin
					if (refresh_cnt_q ==
						ram_pkg::refresh_cnt_t'(ram_pkg::refresh_period - 1)) begin
						state_q <= st_idle;
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	// ------------------------------
	// request accept
	// ------------------------------
	// one request per cycle, none while refreshing
	assign pop = not_empty && (state_q == st_idle);
	assign read_pop = pop && !head_req.wr;

	// low bits only, so segments wrap modulo 16
	assign index = head_req.addr[ram_pkg::ram_size_bits-1:0];

	// writes complete at the pop
	always_ff @(posedge clk) begin
		if (pop && head_req.wr) begin
			mem[index] <= head_req.data;
		end
	end

	// ------------------------------
	// read pipeline
	// ------------------------------
	// array read is stage 0, then plain shift
	always_ff @(posedge clk) begin
		if (read_pop) begin
			data_pipe[0] <= mem[index];
		end
		for (int i = 1; i < ram_pkg::read_latency; i++) begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	// valid travels beside the data
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe[0] <= read_pop;
			for (int i = 1; i < ram_pkg::read_latency; i++) begin
				valid_pipe[i] <= valid_pipe[i-1];
			end
		end
	end

	// exactly read_latency cycles after the pop
	assign rdata = data_pipe[ram_pkg::read_latency-1];
	assign rdata_en = valid_pipe[ram_pkg::read_latency-1];

endmodule

`default_nettype wire

// File: logic/msx_mapper.sv
// memory mapper on the CPU bus
// segment registers, page translation, RAM request issue
// and completion of bus reads
`timescale 1ns/1ps
`default_nettype none

module msx_mapper (
	input wire clk,
	input wire n_reset,
	// CPU bus
	input wire msx_bus_pkg::bus_addr_t bus_address,
	input wire msx_bus_pkg::bus_data_t bus_write_data,
	input wire bus_read,
	input wire bus_write,
	input wire bus_io,
	input wire bus_memory,
	output logic bus_read_ready,
	output msx_bus_pkg::bus_data_t bus_read_data,
	output logic bus_busy,
	// RAM request side
	output ram_pkg::ram_req_t req,
	output logic req_valid,
	input wire busy,
	input wire msx_bus_pkg::bus_data_t rdata,
	input wire rdata_en
);

	// one register per page
	msx_bus_pkg::segment_t seg_q [msx_bus_pkg::mapper_pages];
	msx_bus_pkg::page_t port_page;
	msx_bus_pkg::page_t page;
	msx_bus_pkg::offset_t offset;
	ram_pkg::ram_addr_t phys_addr;
	logic seg_write;
	logic mem_read;
	logic mem_write;
	logic read_pending_q;

	assign mem_read = bus_memory && bus_read;
	assign mem_write = bus_memory && bus_write;

	// ------------------------------
	// segment registers
	// ------------------------------
	// low port bits pick the page
	assign port_page = bus_address[msx_bus_pkg::page_bits-1:0];
	// I/O write to FC..FF, upper port bits must match the base
	assign seg_write = bus_io && bus_write &&
		(bus_address[7:msx_bus_pkg::page_bits] ==
		msx_bus_pkg::mapper_port_base[7:msx_bus_pkg::page_bits]);

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			// every page starts in segment 0
			for (int i = 0; i < msx_bus_pkg::mapper_pages; i++) begin
				seg_q[i] <= '0;
			end
		end else if (seg_write) begin
			seg_q[port_page] <= bus_write_data;
		end
	end

	// ------------------------------
	// page translation
	// ------------------------------
	// page bits out, segment in
	assign page = bus_address[msx_bus_pkg::bus_addr_bits-1 -: msx_bus_pkg::page_bits];
	assign offset = bus_address[msx_bus_pkg::offset_bits-1:0];
	assign phys_addr = {seg_q[page], offset};

	// ------------------------------
	// request issue
	// ------------------------------
	// level rises the cycle after the strobe
	// held until the buffer is not full at an edge
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			req_valid <= 1'b0;
		end else if (mem_read || mem_write) begin
			req_valid <= 1'b1;
		end else if (!busy) begin
			req_valid <= 1'b0;
		end
	end

	// payload, captured with the strobe
	always_ff @(posedge clk) begin
		if (mem_read || mem_write) begin
			req.wr <= mem_write;
			req.addr <= phys_addr;
			// don't care on reads
			req.data <= bus_write_data;
		end
	end

	// host must not strobe memory while this is high
	assign bus_busy = req_valid;

	// ------------------------------
	// read completion
	// ------------------------------
	// one read outstanding at most, host waits for ready
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			read_pending_q <= 1'b0;
		end else if (mem_read) begin
			read_pending_q <= 1'b1;
		end else if (rdata_en) begin
			read_pending_q <= 1'b0;
		end
	end

	assign bus_read_ready = rdata_en && read_pending_q;
	// zero on the bus when nothing completes
	assign bus_read_data = bus_read_ready ? rdata : '0;

endmodule

`default_nettype wire

// File: logic/mapper_ram_top.sv
// mapper RAM subsystem top level
// mapper -> request buffer -> RAM controller
`timescale 1ns/1ps
`default_nettype none

module mapper_ram_top (
	input wire clk,
	input wire n_reset,
	// CPU bus
	input wire msx_bus_pkg::bus_addr_t bus_address,
	input wire msx_bus_pkg::bus_data_t bus_write_data,
	input wire bus_read,
	input wire bus_write,
	input wire bus_io,
	input wire bus_memory,
	output wire bus_read_ready,
	output wire msx_bus_pkg::bus_data_t bus_read_data,
	output wire bus_busy
);

	// mapper to buffer
	ram_pkg::ram_req_t mapper_req;
	logic req_valid;
	logic fifo_full;
	logic fifo_push;
	// buffer to controller
	ram_pkg::ram_req_t head_req;
	logic not_empty;
	logic pop;
	// controller back to mapper
	msx_bus_pkg::bus_data_t rdata;
	logic rdata_en;

	// ------------------------------
	// push handshake
	// ------------------------------
	// taken when not full, the mapper only sees busy
	assign fifo_push = req_valid && !fifo_full;

	msx_mapper mapper_i (
		.clk(clk),
		.n_reset(n_reset),
		.bus_address(bus_address),
		.bus_write_data(bus_write_data),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_io(bus_io),
		.bus_memory(bus_memory),
		.bus_read_ready(bus_read_ready),
		.bus_read_data(bus_read_data),
		.bus_busy(bus_busy),
		.req(mapper_req),
		.req_valid(req_valid),
		.busy(fifo_full),
		.rdata(rdata),
		.rdata_en(rdata_en)
	);

	ram_req_fifo fifo_i (
		.clk(clk),
		.n_reset(n_reset),
		.push_req(mapper_req),
		.push(fifo_push),
		.full(fifo_full),
		.head_req(head_req),
		.not_empty(not_empty),
		.pop(pop)
	);

	ram_array_ctrl ctrl_i (
		.clk(clk),
		.n_reset(n_reset),
		.head_req(head_req),
		.not_empty(not_empty),
		.pop(pop),
		.rdata(rdata),
		.rdata_en(rdata_en)
	);

endmodule

`default_nettype wire

// File: verification/mapper_ram_sva.sv
// concurrent checks bound to the mapper RAM top level
// bus strobe rule, read completion, request hold, read latency
`timescale 1ns/1ps
`default_nettype none

module mapper_ram_sva (
	input wire clk,
	input wire n_reset,
	input wire bus_read,
	input wire bus_write,
	input wire bus_memory,
	input wire bus_busy,
	input wire bus_read_ready,
	input wire ram_pkg::ram_req_t req,
	input wire req_valid,
	input wire busy,
	input wire pop,
	input wire ram_pkg::ram_req_t head_req,
	input wire rdata_en
);

	logic read_open_q;

	// a memory read stays open until its ready pulse
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			read_open_q <= 1'b0;
		end else if (bus_memory && bus_read) begin
			read_open_q <= 1'b1;
		end else if (bus_read_ready) begin
			read_open_q <= 1'b0;
		end
	end

	// ------------------------------
	// bus side
	// ------------------------------
	no_strobe_while_busy: assert property (@(posedge clk) disable iff (!n_reset)
		bus_memory && (bus_read || bus_write) |-> !bus_busy)
		else $error("memory strobe while bus_busy is high");

	ready_needs_read: assert property (@(posedge clk) disable iff (!n_reset)
		bus_read_ready |-> read_open_q)
		else $error("bus_read_ready without an open read");

	// ------------------------------
	// RAM side
	// ------------------------------
	// held request must not change under a full buffer
	req_held_stable: assert property (@(posedge clk) disable iff (!n_reset)
		req_valid && busy |=> req_valid && $stable(req))
		else $error("request changed or dropped while held by busy");

	read_return_time: assert property (@(posedge clk) disable iff (!n_reset)
		pop && !head_req.wr |-> ##(ram_pkg::read_latency) rdata_en)
		else $error("rdata_en missing read_latency cycles after a read pop");

	read_return_cause: assert property (@(posedge clk) disable iff (!n_reset)
		rdata_en |-> $past(pop && !head_req.wr, ram_pkg::read_latency))
		else $error("rdata_en without a read pop read_latency cycles before");

endmodule

bind mapper_ram_top mapper_ram_sva sva_i (
	.clk(clk),
	.n_reset(n_reset),
	.bus_read(bus_read),
	.bus_write(bus_write),
	.bus_memory(bus_memory),
	.bus_busy(bus_busy),
	.bus_read_ready(bus_read_ready),
	.req(mapper_req),
	.req_valid(req_valid),
	.busy(fifo_full),
	.pop(pop),
	.head_req(head_req),
	.rdata_en(rdata_en)
);

`default_nettype wire

// File: verification/mapper_ram_tb.sv
// testbench for the mapper RAM subsystem
// bus tasks, shadow memory model, read compare and report
`timescale 1ns/1ps
`default_nettype none

module mapper_ram_tb;

	localparam int clk_period = 8;
	localparam int reset_cycles = 8;
	localparam int burst_len = 96;
	// bus cycles over all tests, for the watchdog
	localparam int total_ops = 8 + 32 + 20 + 16 + 2 * burst_len;
	// worst case per bus cycle incl. a refresh slot
	localparam int op_cycles = 16;
	localparam int watchdog_cycles = 2 * (reset_cycles + total_ops * op_cycles);

	logic clk;
	logic n_reset;
	msx_bus_pkg::bus_addr_t bus_address;
	msx_bus_pkg::bus_data_t bus_write_data;
	logic bus_read;
	logic bus_write;
	logic bus_io;
	logic bus_memory;
	wire bus_read_ready;
	wire msx_bus_pkg::bus_data_t bus_read_data;
	wire bus_busy;

	// model: shadow RAM and segment copy
	msx_bus_pkg::bus_data_t shadow [2 ** ram_pkg::ram_size_bits];
	msx_bus_pkg::segment_t seg_model [4];
	msx_bus_pkg::bus_data_t expected_q [$];
	string test_name;
	int checks;
	int errors;
	int test_checks;
	int test_errors;
	integer seed;

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	mapper_ram_top dut_i (
		.clk(clk),
		.n_reset(n_reset),
		.bus_address(bus_address),
		.bus_write_data(bus_write_data),
		.bus_read(bus_read),
		.bus_write(bus_write),
		.bus_io(bus_io),
		.bus_memory(bus_memory),
		.bus_read_ready(bus_read_ready),
		.bus_read_data(bus_read_data),
		.bus_busy(bus_busy)
	);

	// ------------------------------
	// reference model
	// ------------------------------
	// segment of the page, modulo 16, above the 14-bit offset
	function automatic ram_pkg::ram_index_t expected_phys(input msx_bus_pkg::bus_addr_t addr);
		msx_bus_pkg::segment_t seg;
		seg = seg_model[addr[15:14]];
		return {seg[3:0], addr[13:0]};
	endfunction

	function automatic msx_bus_pkg::bus_data_t random_byte();
		return msx_bus_pkg::bus_data_t'($random(seed));
	endfunction

	// ------------------------------
	// bus tasks, called on a falling edge
	// ------------------------------
	task automatic io_write(input msx_bus_pkg::bus_addr_t port,
		input msx_bus_pkg::bus_data_t data);
		bus_address = port;
		bus_write_data = data;
		bus_io = 1'b1;
		bus_write = 1'b1;
		// only low byte FC..FF loads a register
		if (port[7:0] >= msx_bus_pkg::mapper_port_base) begin
			seg_model[port[1:0]] = data;
		end
		@(negedge clk);
		bus_io = 1'b0;
		bus_write = 1'b0;
	endtask

	task automatic mem_write(input msx_bus_pkg::bus_addr_t addr,
		input msx_bus_pkg::bus_data_t data);
		while (bus_busy) @(negedge clk);
		bus_address = addr;
		bus_write_data = data;
		bus_memory = 1'b1;
		bus_write = 1'b1;
		shadow[expected_phys(addr)] = data;
		@(negedge clk);
		bus_memory = 1'b0;
		bus_write = 1'b0;
	endtask

	task automatic mem_read(input msx_bus_pkg::bus_addr_t addr);
		while (bus_busy) @(negedge clk);
		bus_address = addr;
		bus_memory = 1'b1;
		bus_read = 1'b1;
		expected_q.push_back(shadow[expected_phys(addr)]);
		@(negedge clk);
		bus_memory = 1'b0;
		bus_read = 1'b0;
		while (!bus_read_ready) @(negedge clk);
	endtask

	// ------------------------------
	// read compare
	// ------------------------------
	always @(negedge clk) begin
		msx_bus_pkg::bus_data_t exp_data;
		if (bus_read_ready) begin
			assert (expected_q.size() > 0) else begin
				$display("bus_read_ready pulsed with no read outstanding in %s", test_name);
				errors++;
			end
			if (expected_q.size() > 0) begin
				exp_data = expected_q.pop_front();
				checks++;
				assert (bus_read_data === exp_data) else begin
					$display("error %s expected %02h actual %02h",
						test_name, exp_data, bus_read_data);
					errors++;
				end
			end
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic finish_test();
		// lets the compare see the last ready pulse
		@(negedge clk);
		$display("test %s finished: %0d checks, %0d errors",
			test_name, checks - test_checks, errors - test_errors);
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	task automatic reset_defaults();
		msx_bus_pkg::bus_addr_t addr;
		start_test("reset_defaults");
		checks++;
		assert (!bus_busy && !bus_read_ready) else begin
			$display("bus_busy or bus_read_ready is high after reset");
			errors++;
		end
		for (int p = 0; p < 4; p++) begin
			addr = {2'(p), 14'(16'h0240 + 16'h0104 * p)};
			mem_write(addr, random_byte());
		end
		// same offset through the next page, all in segment 0
		for (int p = 0; p < 4; p++) begin
			addr = {2'(p + 1), 14'(16'h0240 + 16'h0104 * p)};
			mem_read(addr);
		end
		finish_test();
	endtask

	task automatic page_translation();
		msx_bus_pkg::bus_addr_t addrs [12];
		start_test("page_translation");
		io_write(16'h00FC, 8'h05);
		io_write(16'h00FD, 8'h0A);
		io_write(16'h00FE, 8'h03);
		io_write(16'h00FF, 8'h0E);
		for (int i = 0; i < 12; i++) begin
			addrs[i] = {2'(i % 4), 14'($random(seed))};
			mem_write(addrs[i], random_byte());
		end
		// segments move up one page, each byte read through the next page
		io_write(16'h00FC, 8'h0E);
		io_write(16'h00FD, 8'h05);
		io_write(16'h00FE, 8'h0A);
		io_write(16'h00FF, 8'h03);
		for (int i = 0; i < 12; i++) begin
			mem_read({addrs[i][15:14] + 2'd1, addrs[i][13:0]});
		end
		finish_test();
	endtask

	task automatic segment_wrap();
		start_test("segment_wrap");
		// page 1 written in segment 3, read in segment 19
		io_write(16'h00FD, 8'h03);
		for (int i = 0; i < 4; i++) begin
			mem_write(16'h4100 + 16'(i * 33), random_byte());
		end
		io_write(16'h00FD, 8'h13);
		for (int i = 0; i < 4; i++) begin
			mem_read(16'h4100 + 16'(i * 33));
		end
		// page 2 the other way round
		io_write(16'h00FE, 8'h13);
		for (int i = 0; i < 4; i++) begin
			mem_write(16'h8a00 + 16'(i * 57), random_byte());
		end
		io_write(16'h00FE, 8'h03);
		for (int i = 0; i < 4; i++) begin
			mem_read(16'h8a00 + 16'(i * 57));
		end
		finish_test();
	endtask

	task automatic io_decode();
		start_test("io_decode");
		for (int p = 0; p < 4; p++) begin
			mem_write({2'(p), 14'h1230}, random_byte());
		end
		// ports outside FC..FF
		io_write(16'h00FB, 8'h0C);
		io_write(16'h007C, 8'h0C);
		io_write(16'h00BF, 8'h0C);
		io_write(16'hFCFB, 8'h0C);
		// memory cycles at low byte FC are plain RAM writes
		mem_write(16'h40FC, random_byte());
		mem_write(16'hC0FC, random_byte());
		for (int p = 0; p < 4; p++) begin
			mem_read({2'(p), 14'h1230});
		end
		mem_read(16'h40FC);
		mem_read(16'hC0FC);
		finish_test();
	endtask

	task automatic burst_ordering();
		msx_bus_pkg::bus_addr_t addrs [burst_len];
		start_test("burst_ordering");
		// narrow offsets so some addresses repeat
		for (int i = 0; i < burst_len; i++) begin
			addrs[i] = {2'($random(seed)), 6'h00, random_byte()};
			mem_write(addrs[i], random_byte());
		end
		for (int i = 0; i < burst_len; i++) begin
			mem_read(addrs[i]);
		end
		finish_test();
	endtask

	// ------------------------------
	// main sequence and watchdog
	// ------------------------------
	initial begin
		seed = 32'h1742_9d93;
		n_reset = 1'b0;
		bus_address = '0;
		bus_write_data = '0;
		bus_read = 1'b0;
		bus_write = 1'b0;
		bus_io = 1'b0;
		bus_memory = 1'b0;
		checks = 0;
		errors = 0;
		test_name = "reset";
		for (int p = 0; p < 4; p++) begin
			seg_model[p] = '0;
		end
		repeat (reset_cycles) @(negedge clk);
		n_reset = 1'b1;
		@(negedge clk);
		reset_defaults();
		page_translation();
		segment_wrap();
		io_decode();
		burst_ordering();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
logic/msx_bus_pkg.sv
logic/ram_pkg.sv
logic/ram_req_fifo.sv
logic/ram_array_ctrl.sv
logic/msx_mapper.sv
logic/mapper_ram_top.sv
verification/mapper_ram_sva.sv
verification/mapper_ram_tb.sv

// File: Bender.yml
package:
  name: mapper_ram

sources:
  # packages first, bus side before memory side
  - logic/msx_bus_pkg.sv
  - logic/ram_pkg.sv
  - logic/ram_req_fifo.sv
  - logic/ram_array_ctrl.sv
  - logic/msx_mapper.sv
  - logic/mapper_ram_top.sv
  - target: simulation
    files:
      - verification/mapper_ram_sva.sv
      - verification/mapper_ram_tb.sv
